// ==== cpu_bram_bus.f ====
+incdir+verilog
verilog/bus_pkg.sv
verilog/bus_ctrl.sv
verilog/ctl_regs.sv
verilog/mod_mem.sv
verilog/stm_mem.sv
verilog/duty_table.sv
verilog/cpu_bram_bus.sv
test/tb_cpu_bram_bus.sv

// ==== test/tb_cpu_bram_bus.sv ====
`include "bus_defs.svh"

module tb_cpu_bram_bus;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACCESS_COUNT  = 500;  // Bus and port accesses over all six tests
  localparam int ACCESS_CYCLES = 8;

  logic                    CPU_CKIO;
  logic                    arst_n;
  logic                    cpu_cn;
  logic                    cpu_we_n;
  logic [16:0]             cpu_addr;
  logic [`BUS_DATA_W-1:0]  cpu_data_in;
  logic [`BUS_DATA_W-1:0]  cpu_data_read;
  logic                    mod_rd_segment;
  logic [`MOD_DEPTH_W:0]   mod_rd_idx;
  logic [7:0]              mod_rd_byte;
  logic                    stm_rd_segment;
  logic [`STM_PAGE_W-1:0]  stm_rd_page;
  logic [`STM_DEPTH_W-1:0] stm_rd_addr;
  logic [`BUS_DATA_W-1:0]  stm_rd_data;
  logic [`DUTY_DEPTH_W+1:0] duty_rd_idx;
  logic [7:0]              duty_rd_byte;

  logic [`BUS_DATA_W-1:0] main_model [256];
  logic [`BUS_DATA_W-1:0] mod_model  [512];  // Segment in the top index bit
  logic [`BUS_DATA_W-1:0] duty_model [512];
  integer seed;
  int     errors;
  int     checks;
  int     test_start;

  cpu_bram_bus uut (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .cpu_cn(cpu_cn), .cpu_we_n(cpu_we_n),
    .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .cpu_data_read(cpu_data_read),
    .mod_rd_segment(mod_rd_segment), .mod_rd_idx(mod_rd_idx), .mod_rd_byte(mod_rd_byte),
    .stm_rd_segment(stm_rd_segment), .stm_rd_page(stm_rd_page), .stm_rd_addr(stm_rd_addr),
    .stm_rd_data(stm_rd_data), .duty_rd_idx(duty_rd_idx), .duty_rd_byte(duty_rd_byte)
  );

  always #4 CPU_CKIO = ~CPU_CKIO;

  function automatic logic [`BUS_ADDR_W-1:0] main_addr(input logic [7:0] a);
    return {2'b00, `CNT_SELECT_MAIN, a};
  endfunction

  function automatic logic [`BUS_ADDR_W-1:0] clk_addr(input logic [4:0] idx,
                                                      input logic [1:0] w);
    return {2'b00, `CNT_SELECT_CLOCK, 1'b0, idx, w};
  endfunction

  function automatic logic [`BUS_ADDR_W-1:0] filter_addr(input logic [6:0] a);
    return {2'b00, `CNT_SELECT_FILTER, 1'b0, a};
  endfunction

  // Odd byte index selects the high byte
  function automatic logic [7:0] pick_byte(input logic [15:0] w, input int b);
    return (b % 2) ? w[15:8] : w[7:0];
  endfunction

  task automatic held_write(input logic [1:0] sel, input logic [`BUS_ADDR_W-1:0] addr,
                            input logic [`BUS_DATA_W-1:0] first,
                            input logic [`BUS_DATA_W-1:0] late);
    @(posedge CPU_CKIO);
    #1;
    cpu_cn = 1'b0;
    cpu_we_n = 1'b0;
    cpu_addr = {sel, addr, 1'b0};
    cpu_data_in = first;
    repeat (2) @(posedge CPU_CKIO);
    #1;
    cpu_data_in = late;  // Strobe stays low for four sampled cycles
    repeat (2) @(posedge CPU_CKIO);
    #1;
    cpu_cn = 1'b1;
    cpu_we_n = 1'b1;
    repeat (2) @(posedge CPU_CKIO);
  endtask

  task automatic bus_write(input logic [1:0] sel, input logic [`BUS_ADDR_W-1:0] addr,
                           input logic [`BUS_DATA_W-1:0] data);
    held_write(sel, addr, data, data);
  endtask

  task automatic bus_read(input logic [1:0] sel, input logic [`BUS_ADDR_W-1:0] addr,
                          output logic [`BUS_DATA_W-1:0] data);
    @(posedge CPU_CKIO);
    #1;
    cpu_cn = 1'b0;
    cpu_we_n = 1'b1;
    cpu_addr = {sel, addr, 1'b0};
    repeat (3) @(posedge CPU_CKIO);  // Read data lands two edges after the first sample
    #1;
    data = cpu_data_read;
    cpu_cn = 1'b1;
  endtask

  task automatic read_mod_byte(input logic seg, input logic [`MOD_DEPTH_W:0] idx,
                               output logic [7:0] b);
    @(posedge CPU_CKIO);
    #1;
    mod_rd_segment = seg;
    mod_rd_idx = idx;
    @(posedge CPU_CKIO);
    #1;
    b = mod_rd_byte;
  endtask

  task automatic read_stm_word(input logic seg, input logic [`STM_PAGE_W-1:0] page,
                               input logic [`STM_DEPTH_W-1:0] addr,
                               output logic [`BUS_DATA_W-1:0] w);
    @(posedge CPU_CKIO);
    #1;
    stm_rd_segment = seg;
    stm_rd_page = page;
    stm_rd_addr = addr;
    @(posedge CPU_CKIO);
    #1;
    w = stm_rd_data;
  endtask

  task automatic read_duty_byte(input logic [`DUTY_DEPTH_W+1:0] idx, output logic [7:0] b);
    @(posedge CPU_CKIO);
    #1;
    duty_rd_idx = idx;
    @(posedge CPU_CKIO);
    #1;
    b = duty_rd_byte;
  endtask

  task automatic check_word(input string name, input logic [`BUS_DATA_W-1:0] got,
                            input logic [`BUS_DATA_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input string name);
    $display("%-16s %s, %0d errors", name, (errors == test_start) ? "ok" : "mismatches",
             errors - test_start);
  endtask

  task automatic test_reset_values();
    logic [`BUS_DATA_W-1:0] rd;
    test_start = errors;
    check_word("cpu_data_read", cpu_data_read, '0);  // Nothing read since reset
    for (int i = 0; i < 4; i++) begin
      bus_read(`SEL_CONTROLLER, main_addr(8'(i * 37)), rd);
      check_word("cpu_data_read", rd, '0);
      bus_read(`SEL_CONTROLLER, clk_addr(5'(i * 9), 2'(i % 3)), rd);
      check_word("cpu_data_read", rd, '0);
      bus_read(`SEL_CONTROLLER, filter_addr(7'(i * 31)), rd);
      check_word("cpu_data_read", rd, '0);
    end
    report_test("reset values");
  endtask

  task automatic test_main_regs();
    logic [`BUS_DATA_W-1:0] rd;
    test_start = errors;
    for (int i = 0; i < 16; i++) begin
      main_model[8'(i * 17)] = 16'($random(seed));
      bus_write(`SEL_CONTROLLER, main_addr(8'(i * 17)), main_model[8'(i * 17)]);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(`SEL_CONTROLLER, main_addr(8'(i * 17)), rd);
      check_word("cpu_data_read", rd, main_model[8'(i * 17)]);
    end
    report_test("main registers");
  endtask

  task automatic test_clock_view();
    logic [`BUS_DATA_W-1:0] rd;
    logic [`BUS_DATA_W-1:0] clk_words [96];
    logic [7:0]             low;
    test_start = errors;
    for (int i = 0; i < 96; i++) begin
      clk_words[i] = 16'($random(seed));
      bus_write(`SEL_CONTROLLER, clk_addr(5'(i / 3), 2'(i % 3)), clk_words[i]);
    end
    for (int i = 0; i < 96; i++) begin
      low = {1'b0, 5'(i / 3), 2'(i % 3)};  // Main register sharing the low address bits
      bus_read(`SEL_CONTROLLER, clk_addr(5'(i / 3), 2'(i % 3)), rd);
      check_word("cpu_data_read", rd, clk_words[i]);
      bus_read(`SEL_CONTROLLER, main_addr(low), rd);
      check_word("cpu_data_read", rd, main_model[low]);
    end
    report_test("clock view");
  endtask

  task automatic test_mod_mem();
    logic [7:0] rb;
    test_start = errors;
    for (int s = 0; s < 2; s++) begin
      bus_write(`SEL_CONTROLLER, main_addr(`ADDR_MOD_MEM_WR_SEGMENT), 16'(s));
      for (int a = 0; a < 16; a++) begin
        mod_model[s * 256 + a] = (s == 0) ? 16'($random(seed)) : ~mod_model[a];
        bus_write(`SEL_MOD, 14'(a), mod_model[s * 256 + a]);
      end
    end
    for (int s = 0; s < 2; s++) begin
      for (int b = 0; b < 32; b++) begin
        read_mod_byte(1'(s), 9'(b), rb);
        check_byte("mod_rd_byte", rb, pick_byte(mod_model[s * 256 + b / 2], b));
      end
    end
    report_test("mod memory");
  endtask

  task automatic test_stm_mem();
    logic [`BUS_DATA_W-1:0] rd;
    logic [`BUS_DATA_W-1:0] stm_words [4];
    test_start = errors;
    for (int k = 0; k < 4; k++) begin
      stm_words[k] = 16'h5a00 + 16'(k * 16'h0111);
      bus_write(`SEL_CONTROLLER, main_addr(`ADDR_STM_MEM_WR_SEGMENT), 16'(k / 2));
      bus_write(`SEL_CONTROLLER, main_addr(`ADDR_STM_MEM_WR_PAGE), 16'(k % 2));
      bus_write(`SEL_STM, 14'h37, stm_words[k]);
    end
    for (int k = 0; k < 4; k++) begin
      read_stm_word(1'(k / 2), 2'(k % 2), 8'h37, rd);
      check_word("stm_rd_data", rd, stm_words[k]);
    end
    // Segment is still 1 here and only the first data word may land
    bus_write(`SEL_CONTROLLER, main_addr(`ADDR_STM_MEM_WR_PAGE), 16'd2);
    held_write(`SEL_STM, 14'h11, 16'hc0de, 16'hbad0);
    read_stm_word(1'b1, 2'd2, 8'h11, rd);
    check_word("stm_rd_data", rd, 16'hc0de);
    report_test("stm memory");
  endtask

  task automatic test_duty_table();
    logic [7:0] rb;
    test_start = errors;
    for (int p = 0; p < 2; p++) begin
      bus_write(`SEL_CONTROLLER, main_addr(`ADDR_DUTY_TABLE_WR_PAGE), 16'(p));
      for (int a = 0; a < 8; a++) begin
        duty_model[p * 256 + a] = 16'($random(seed));
        bus_write(`SEL_DUTY_TABLE, 14'(a), duty_model[p * 256 + a]);
      end
    end
    @(posedge CPU_CKIO);
    #1;
    cpu_we_n = 1'b0;  // Chip enable stays high
    cpu_addr = {`SEL_DUTY_TABLE, 14'd3, 1'b0};
    cpu_data_in = ~duty_model[256 + 3];
    repeat (3) @(posedge CPU_CKIO);
    #1;
    cpu_we_n = 1'b1;
    for (int p = 0; p < 2; p++) begin
      for (int b = 0; b < 16; b++) begin
        read_duty_byte(10'(p * 512 + b), rb);
        check_byte("duty_rd_byte", rb, pick_byte(duty_model[p * 256 + b / 2], b));
      end
    end
    report_test("duty table");
  endtask

  initial begin
    #(ACCESS_COUNT * ACCESS_CYCLES * 8 * 2 + 64);
    $display("Watchdog expired before the tests finished");
    $display("tests failed");
    $finish;
  end

  initial begin
    seed = 32'hedd82855;
    errors = 0;
    checks = 0;
    test_start = 0;
    CPU_CKIO = 1'b0;
    arst_n = 1'b0;
    cpu_cn = 1'b1;
    cpu_we_n = 1'b1;
    cpu_addr = '0;
    cpu_data_in = '0;
    mod_rd_segment = 1'b0;
    mod_rd_idx = '0;
    stm_rd_segment = 1'b0;
    stm_rd_page = '0;
    stm_rd_addr = '0;
    duty_rd_idx = '0;
    for (int i = 0; i < 256; i++) begin
      main_model[i] = '0;
    end
    repeat (8) @(posedge CPU_CKIO);
    #1;
    arst_n = 1'b1;
    test_reset_values();
    test_main_regs();
    test_clock_view();
    test_mod_mem();
    test_stm_mem();
    test_duty_table();
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog/bus_ctrl.sv ====
`include "bus_defs.svh"

module bus_ctrl (
  input  logic                   CPU_CKIO,
  input  logic                   arst_n,
  input  logic                   cpu_cn,
  input  logic                   cpu_we_n,
  input  logic [16:0]            cpu_addr,
  input  logic [`BUS_DATA_W-1:0] cpu_data_in,
  input  bus_pkg::wr_ctx_t       wr_ctx,
  input  logic [`BUS_DATA_W-1:0] rd_data,
  output bus_pkg::mem_wr_t       ctl_wr,
  output logic [`BUS_ADDR_W-1:0] ctl_rd_addr,
  output bus_pkg::mem_wr_t       mod_wr,
  output bus_pkg::mem_wr_t       stm_wr,
  output bus_pkg::mem_wr_t       duty_wr,
  output logic [`BUS_DATA_W-1:0] cpu_data_read
);

  bus_pkg::bus_req_t      req_q;
  logic                   we_prev_q;
  logic                   wr_start;
  logic                   rd_ctl;
  logic                   rd_ctl_q;
  logic [15:0]            full_addr;
  logic [3:0]             wr_sel_q;  // Controller, mod, STM, duty
  logic [15:0]            wr_addr_q;
  logic [`BUS_DATA_W-1:0] wr_data_q;

  // Bit 0 of cpu_addr is fixed on this bus
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      req_q     <= '0;
      we_prev_q <= 1'b0;
    end else begin
      req_q <= '{en: ~cpu_cn, we: ~cpu_we_n, sel: cpu_addr[16:15], addr: cpu_addr[14:1],
                 data: cpu_data_in};
      we_prev_q <= req_q.we;
    end
  end

  assign wr_start = req_q.en & req_q.we & ~we_prev_q;  // First cycle of a low strobe only
  assign rd_ctl = req_q.en & ~req_q.we & (req_q.sel == `SEL_CONTROLLER);

  always_comb begin
    case (req_q.sel)
      `SEL_MOD: full_addr = 16'({wr_ctx.mod_segment, req_q.addr[`MOD_DEPTH_W-1:0]});
      `SEL_STM: full_addr = 16'({wr_ctx.stm_segment, wr_ctx.stm_page,
                                 req_q.addr[`STM_DEPTH_W-1:0]});
      `SEL_DUTY_TABLE: full_addr = 16'({wr_ctx.duty_page, req_q.addr[`DUTY_DEPTH_W-1:0]});
      default: full_addr = 16'(req_q.addr);
    endcase
  end

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      wr_sel_q      <= '0;
      rd_ctl_q      <= 1'b0;
      cpu_data_read <= '0;
    end else begin
      wr_sel_q[0] <= wr_start & (req_q.sel == `SEL_CONTROLLER);
      wr_sel_q[1] <= wr_start & (req_q.sel == `SEL_MOD);
      wr_sel_q[2] <= wr_start & (req_q.sel == `SEL_STM);
      wr_sel_q[3] <= wr_start & (req_q.sel == `SEL_DUTY_TABLE);
      rd_ctl_q    <= rd_ctl;
      if (rd_ctl_q) begin
        cpu_data_read <= rd_data;  // Register file answered one edge earlier
      end
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if (wr_start) begin
      wr_addr_q <= full_addr;
      wr_data_q <= req_q.data;
    end
  end

  assign ctl_rd_addr = req_q.addr;

  assign ctl_wr  = '{we: wr_sel_q[0], addr: wr_addr_q, data: wr_data_q};
  assign mod_wr  = '{we: wr_sel_q[1], addr: wr_addr_q, data: wr_data_q};
  assign stm_wr  = '{we: wr_sel_q[2], addr: wr_addr_q, data: wr_data_q};
  assign duty_wr = '{we: wr_sel_q[3], addr: wr_addr_q, data: wr_data_q};

endmodule

// ==== verilog/bus_defs.svh ====
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// Word address inside one target and the shared data word
`define BUS_ADDR_W 14
`define BUS_DATA_W 16

// Target select taken from cpu_addr[16:15]
`define SEL_CONTROLLER 2'b00
`define SEL_MOD        2'b01
`define SEL_DUTY_TABLE 2'b10
`define SEL_STM        2'b11

// Areas inside the controller target
`define CNT_SELECT_MAIN   4'h0
`define CNT_SELECT_CLOCK  4'h1
`define CNT_SELECT_FILTER 4'h2

`define ADDR_MOD_MEM_WR_SEGMENT 8'h20
`define ADDR_STM_MEM_WR_SEGMENT 8'h40
`define ADDR_STM_MEM_WR_PAGE    8'h41
`define ADDR_DUTY_TABLE_WR_PAGE 8'h50

// Memory sizes are kept small so the simulation stays light
`define MOD_DEPTH_W    8
`define STM_PAGE_W     2
`define STM_DEPTH_W    8
`define DUTY_DEPTH_W   8
`define CLK_ROM_W      5
`define FILTER_DEPTH_W 7

`endif

// ==== verilog/bus_pkg.sv ====
`include "bus_defs.svh"

package bus_pkg;

  // One sampled cycle of the CPU bus
  typedef struct packed {
    logic                   en;
    logic                   we;
    logic [1:0]             sel;
    logic [`BUS_ADDR_W-1:0] addr;
    logic [`BUS_DATA_W-1:0] data;
  } bus_req_t;

  typedef struct packed {
    logic [1:0] pad;
    logic [3:0] area;
    logic [7:0] addr;
  } ctl_reg_view_t;

  typedef struct packed {
    logic [1:0]            pad;
    logic [3:0]            area;
    logic                  pad_idx;
    logic [`CLK_ROM_W-1:0] idx;
    logic [1:0]            word;  // Three words per clock entry
  } ctl_clk_view_t;

  typedef union packed {
    ctl_reg_view_t regs;
    ctl_clk_view_t clk;
  } ctl_addr_u;

  // Segment and page numbers applied to datapath writes
  typedef struct packed {
    logic                   mod_segment;
    logic                   stm_segment;
    logic [`STM_PAGE_W-1:0] stm_page;
    logic                   duty_page;
  } wr_ctx_t;

  typedef struct packed {
    logic                   we;
    logic [15:0]            addr;
    logic [`BUS_DATA_W-1:0] data;
  } mem_wr_t;

endpackage

// ==== verilog/cpu_bram_bus.sv ====
`include "bus_defs.svh"

module cpu_bram_bus (
  input  logic                    CPU_CKIO,
  input  logic                    arst_n,
  input  logic                    cpu_cn,
  input  logic                    cpu_we_n,
  input  logic [16:0]             cpu_addr,
  input  logic [`BUS_DATA_W-1:0]  cpu_data_in,
  output logic [`BUS_DATA_W-1:0]  cpu_data_read,
  input  logic                    mod_rd_segment,
  input  logic [`MOD_DEPTH_W:0]   mod_rd_idx,
  output logic [7:0]              mod_rd_byte,
  input  logic                    stm_rd_segment,
  input  logic [`STM_PAGE_W-1:0]  stm_rd_page,
  input  logic [`STM_DEPTH_W-1:0] stm_rd_addr,
  output logic [`BUS_DATA_W-1:0]  stm_rd_data,
  input  logic [`DUTY_DEPTH_W+1:0] duty_rd_idx,
  output logic [7:0]              duty_rd_byte
);

  bus_pkg::mem_wr_t       ctl_wr;
  bus_pkg::mem_wr_t       mod_wr;
  bus_pkg::mem_wr_t       stm_wr;
  bus_pkg::mem_wr_t       duty_wr;
  bus_pkg::wr_ctx_t       wr_ctx;
  logic [`BUS_ADDR_W-1:0] ctl_rd_addr;
  logic [`BUS_DATA_W-1:0] rd_data;

  bus_ctrl u_bus_ctrl (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .cpu_cn(cpu_cn), .cpu_we_n(cpu_we_n),
    .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .wr_ctx(wr_ctx), .rd_data(rd_data),
    .ctl_wr(ctl_wr), .ctl_rd_addr(ctl_rd_addr), .mod_wr(mod_wr), .stm_wr(stm_wr),
    .duty_wr(duty_wr), .cpu_data_read(cpu_data_read)
  );

  ctl_regs u_ctl_regs (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .ctl_wr(ctl_wr), .ctl_rd_addr(ctl_rd_addr),
    .rd_data(rd_data), .wr_ctx(wr_ctx)
  );

  mod_mem u_mod_mem (
    .CPU_CKIO(CPU_CKIO), .mod_wr(mod_wr), .mod_rd_segment(mod_rd_segment),
    .mod_rd_idx(mod_rd_idx), .mod_rd_byte(mod_rd_byte)
  );

  stm_mem u_stm_mem (
    .CPU_CKIO(CPU_CKIO), .stm_wr(stm_wr), .stm_rd_segment(stm_rd_segment),
    .stm_rd_page(stm_rd_page), .stm_rd_addr(stm_rd_addr), .stm_rd_data(stm_rd_data)
  );

  duty_table u_duty_table (
    .CPU_CKIO(CPU_CKIO), .duty_wr(duty_wr), .duty_rd_idx(duty_rd_idx),
    .duty_rd_byte(duty_rd_byte)
  );

endmodule

// ==== verilog/ctl_regs.sv ====
`include "bus_defs.svh"

module ctl_regs (
  input  logic                   CPU_CKIO,
  input  logic                   arst_n,
  input  bus_pkg::mem_wr_t       ctl_wr,
  input  logic [`BUS_ADDR_W-1:0] ctl_rd_addr,
  output logic [`BUS_DATA_W-1:0] rd_data,
  output bus_pkg::wr_ctx_t       wr_ctx
);

  bus_pkg::ctl_addr_u     wa;
  bus_pkg::ctl_addr_u     ra;
  logic [`BUS_DATA_W-1:0] main_q   [256];
  logic [`BUS_DATA_W-1:0] clk_q    [2**`CLK_ROM_W][3];
  logic [`BUS_DATA_W-1:0] filter_q [2**`FILTER_DEPTH_W];

  assign wa = ctl_wr.addr[`BUS_ADDR_W-1:0];
  assign ra = ctl_rd_addr;

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      main_q   <= '{default: '0};
      clk_q    <= '{default: '0};
      filter_q <= '{default: '0};
    end else if (ctl_wr.we) begin
      case (wa.regs.area)
        `CNT_SELECT_MAIN: main_q[wa.regs.addr] <= ctl_wr.data;
        `CNT_SELECT_CLOCK: begin
          if (wa.clk.word != 2'd3) begin
            clk_q[wa.clk.idx][wa.clk.word] <= ctl_wr.data;
          end
        end
        `CNT_SELECT_FILTER: filter_q[wa.regs.addr[`FILTER_DEPTH_W-1:0]] <= ctl_wr.data;
        default: ;  // Unknown areas drop the write
      endcase
    end
  end

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      rd_data <= '0;
    end else begin
      case (ra.regs.area)
        `CNT_SELECT_MAIN: rd_data <= main_q[ra.regs.addr];
        `CNT_SELECT_CLOCK: begin
          // Word select 3 has no storage behind it
          rd_data <= (ra.clk.word == 2'd3) ? '0 : clk_q[ra.clk.idx][ra.clk.word];
        end
        `CNT_SELECT_FILTER: rd_data <= filter_q[ra.regs.addr[`FILTER_DEPTH_W-1:0]];
        default: rd_data <= '0;
      endcase
    end
  end

  assign wr_ctx = '{
    mod_segment: main_q[`ADDR_MOD_MEM_WR_SEGMENT][0],
    stm_segment: main_q[`ADDR_STM_MEM_WR_SEGMENT][0],
    stm_page:    main_q[`ADDR_STM_MEM_WR_PAGE][`STM_PAGE_W-1:0],
    duty_page:   main_q[`ADDR_DUTY_TABLE_WR_PAGE][0]
  };

endmodule

// ==== verilog/duty_table.sv ====
`include "bus_defs.svh"

module duty_table (
  input  logic                    CPU_CKIO,
  input  bus_pkg::mem_wr_t        duty_wr,
  input  logic [`DUTY_DEPTH_W+1:0] duty_rd_idx,
  output logic [7:0]              duty_rd_byte
);

  logic [`BUS_DATA_W-1:0] mem [2**(`DUTY_DEPTH_W+1)];
  logic [`BUS_DATA_W-1:0] rd_word;

  // Top bit of the byte index is the page
  assign rd_word = mem[duty_rd_idx[`DUTY_DEPTH_W+1:1]];

  always_ff @(posedge CPU_CKIO) begin
    if (duty_wr.we) begin
      mem[duty_wr.addr[`DUTY_DEPTH_W:0]] <= duty_wr.data;
    end
    duty_rd_byte <= duty_rd_idx[0] ? rd_word[15:8] : rd_word[7:0];
  end

endmodule

// ==== verilog/mod_mem.sv ====
`include "bus_defs.svh"

module mod_mem (
  input  logic                 CPU_CKIO,
  input  bus_pkg::mem_wr_t     mod_wr,
  input  logic                 mod_rd_segment,
  input  logic [`MOD_DEPTH_W:0] mod_rd_idx,
  output logic [7:0]           mod_rd_byte
);

  // Both segments live in one array with the segment as top address bit
  logic [`BUS_DATA_W-1:0] mem [2**(`MOD_DEPTH_W+1)];
  logic [`BUS_DATA_W-1:0] rd_word;

  assign rd_word = mem[{mod_rd_segment, mod_rd_idx[`MOD_DEPTH_W:1]}];

  always_ff @(posedge CPU_CKIO) begin
    if (mod_wr.we) begin
      mem[mod_wr.addr[`MOD_DEPTH_W:0]] <= mod_wr.data;
    end
  end

  // Even byte index gives the low byte of the word
  always_ff @(posedge CPU_CKIO) begin
    mod_rd_byte <= mod_rd_idx[0] ? rd_word[15:8] : rd_word[7:0];
  end

endmodule

// ==== verilog/stm_mem.sv ====
`include "bus_defs.svh"

module stm_mem (
  input  logic                    CPU_CKIO,
  input  bus_pkg::mem_wr_t        stm_wr,
  input  logic                    stm_rd_segment,
  input  logic [`STM_PAGE_W-1:0]  stm_rd_page,
  input  logic [`STM_DEPTH_W-1:0] stm_rd_addr,
  output logic [`BUS_DATA_W-1:0]  stm_rd_data
);

  // Word index is segment, then page, then address within the page
  logic [`BUS_DATA_W-1:0] mem [2**(1+`STM_PAGE_W+`STM_DEPTH_W)];

  always_ff @(posedge CPU_CKIO) begin
    if (stm_wr.we) begin
      mem[stm_wr.addr[`STM_PAGE_W+`STM_DEPTH_W:0]] <= stm_wr.data;
    end
    stm_rd_data <= mem[{stm_rd_segment, stm_rd_page, stm_rd_addr}];
  end

endmodule
